/* source/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ########################################
// Data memory geometry
// ########################################

// Low address bits that index the data memory as bytes.
// Ten bits give a 1 KiB memory.
`define DM_ADDR_WIDTH 10

// Number of 32-bit words held by the data memory.
`define DM_SIZE ((1 << `DM_ADDR_WIDTH) / 4)

`endif

/* source/mem_pkg.sv */
package mem_pkg;

	// ########################################
	// Access modes
	// ########################################

	// One encoding serves loads and stores.
	// Stores only make sense for w, h and b.
	typedef enum logic [2:0] {
		mode_none = 3'd0, // No access this cycle.
		mode_w    = 3'd1,
		mode_h    = 3'd2, // Signed halfword.
		mode_hu   = 3'd3,
		mode_b    = 3'd4, // Signed byte.
		mode_bu   = 3'd5
	} mem_mode_t;

endpackage

/* source/mem_access_check.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module mem_access_check import mem_pkg::*; (
	input  logic [31:0]               read_addr,
	input  logic [31:0]               write_addr,
	input  logic [31:0]               write_data,
	input  logic                      write_enable,
	input  mem_mode_t                 mode,
	input  logic                      rst_n,
	output logic                      invalid,
	output logic [1:0]                offset,
	output logic [3:0]                byte_en,
	output logic [31:0]               lane_data,
	output logic [`DM_ADDR_WIDTH-3:0] word_index,
	output logic [`DM_ADDR_WIDTH-3:0] read_index
);

	logic [31:0] op_addr;
	logic [3:0]  lane_mask;
	logic        store_ok;

	// ########################################
	// Address selection and alignment
	// ########################################

	// A store owns the address whenever it is present.
	assign op_addr = write_enable ? write_addr : read_addr;

	always_comb begin
		case (mode)
			mode_w: begin
				invalid = (op_addr[1:0] != 2'b00);
			end
			mode_h, mode_hu: begin
				invalid = op_addr[0];
			end
			default: begin
				invalid = 1'b0; // Bytes and idle cycles are always aligned.
			end
		endcase
	end

	assign read_index = read_addr[`DM_ADDR_WIDTH-1:2];
	assign word_index = write_addr[`DM_ADDR_WIDTH-1:2];
	assign offset     = read_addr[1:0];

	// ########################################
	// Store lanes
	// ########################################

	always_comb begin
		case (mode)
			mode_w: begin
				lane_mask = 4'b1111;
			end
			mode_h: begin
				lane_mask = op_addr[1] ? 4'b1100 : 4'b0011;
			end
			mode_b: begin
				lane_mask = 4'b0001 << op_addr[1:0];
			end
			default: begin
				lane_mask = 4'b0000; // Unsigned modes are loads only.
			end
		endcase
	end

	// The RAM takes the data in place, so the source is copied into every lane.
	always_comb begin
		case (mode)
			mode_h: begin
				lane_data = {2{write_data[15:0]}};
			end
			mode_b: begin
				lane_data = {4{write_data[7:0]}};
			end
			default: begin
				lane_data = write_data;
			end
		endcase
	end

	assign store_ok = write_enable && !invalid && rst_n;
	assign byte_en  = store_ok ? lane_mask : 4'b0000; // No lane moves while in reset.

endmodule

/* source/data_ram.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module data_ram import mem_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [3:0]                byte_en,
	input  logic [31:0]               lane_data,
	input  logic [`DM_ADDR_WIDTH-3:0] word_index,
	input  logic [`DM_ADDR_WIDTH-3:0] read_index,
	output logic [31:0]               rdata
);

	// ########################################
	// Storage
	// ########################################

	logic [31:0] mem [`DM_SIZE];

	// Each byte lane is written on its own.
	// Reset wipes the whole array so loads after reset see zero.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int w = 0; w < `DM_SIZE; w++) begin
				mem[w] <= 32'h0000_0000;
			end
		end else begin
			for (int lane = 0; lane < 4; lane++) begin
				if (byte_en[lane]) begin
					mem[word_index][8*lane +: 8] <= lane_data[8*lane +: 8];
				end
			end
		end
	end

	// ########################################
	// Read port
	// ########################################

	// Same-cycle store and load return the contents before the edge.
	assign rdata = mem[read_index];

endmodule

/* source/load_align.sv */
`timescale 1ns/10ps

module load_align import mem_pkg::*; (
	input  logic [31:0] rdata,
	input  mem_mode_t   mode,
	input  logic [1:0]  offset,
	input  logic        invalid,
	output logic [31:0] read_result
);

	logic [15:0] half_sel;
	logic [7:0]  byte_sel;

	// ########################################
	// Lane selection
	// ########################################

	assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0]; // Offset bit 0 is checked upstream.

	always_comb begin
		case (offset)
			2'b00: begin
				byte_sel = rdata[7:0];
			end
			2'b01: begin
				byte_sel = rdata[15:8];
			end
			2'b10: begin
				byte_sel = rdata[23:16];
			end
			default: begin
				byte_sel = rdata[31:24];
			end
		endcase
	end

	// ########################################
	// Extension
	// ########################################

	always_comb begin
		if (invalid) begin
			read_result = 32'h0000_0000; // A misaligned load returns nothing.
		end else begin
			case (mode)
				mode_w: begin
					read_result = rdata;
				end
				mode_h: begin
					read_result = {{16{half_sel[15]}}, half_sel};
				end
				mode_hu: begin
					read_result = {16'h0000, half_sel};
				end
				mode_b: begin
					read_result = {{24{byte_sel[7]}}, byte_sel};
				end
				mode_bu: begin
					read_result = {24'h00_0000, byte_sel};
				end
				default: begin
					read_result = 32'h0000_0000;
				end
			endcase
		end
	end

endmodule

/* source/mem_stage.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module mem_stage import mem_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] read_addr,
	input  logic [31:0] write_addr,
	input  logic [31:0] write_data,
	input  logic        write_enable,
	input  mem_mode_t   mode,
	output logic [31:0] read_result,
	output logic        invalid
);

	logic [3:0]                byte_en;
	logic [31:0]               lane_data;
	logic [31:0]               rdata;
	logic [1:0]                offset;
	logic [`DM_ADDR_WIDTH-3:0] word_index;
	logic [`DM_ADDR_WIDTH-3:0] read_index;

	// ########################################
	// Input side
	// ########################################

	mem_access_check check0 (
		.read_addr    (read_addr),
		.write_addr   (write_addr),
		.write_data   (write_data),
		.write_enable (write_enable),
		.mode         (mode),
		.rst_n        (rst_n),
		.invalid      (invalid),
		.offset       (offset),
		.byte_en      (byte_en),
		.lane_data    (lane_data),
		.word_index   (word_index),
		.read_index   (read_index)
	);

	// Word store with a combinational read.
	data_ram ram0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.byte_en    (byte_en),
		.lane_data  (lane_data),
		.word_index (word_index),
		.read_index (read_index),
		.rdata      (rdata)
	);

	// ########################################
	// Output side
	// ########################################

	load_align align0 (
		.rdata       (rdata),
		.mode        (mode),
		.offset      (offset),
		.invalid     (invalid),
		.read_result (read_result)
	);

endmodule

/* verification/mem_stage_tb.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module mem_stage_tb import mem_pkg::*; ();

	localparam int AW              = `DM_ADDR_WIDTH;
	localparam int CLK_PERIOD      = 4;
	localparam int RESET_CYCLES    = 10;
	localparam int DIRECTED_CYCLES = 120; // Upper bound over tests 1 to 5, idle cycles included.
	localparam int RANDOM_OPS      = 500;
	localparam int TIMEOUT_NS      = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_OPS + 1)
		* CLK_PERIOD + 200;

	logic        clk;
	logic        rst_n;
	logic [31:0] read_addr;
	logic [31:0] write_addr;
	logic [31:0] write_data;
	logic        write_enable;
	mem_mode_t   mode;
	logic [31:0] read_result;
	logic        invalid;

	logic [7:0]  shadow [1 << AW]; // Byte model of the data memory.
	logic [31:0] exp_result;
	logic        exp_invalid;
	logic        check_en;
	string       cur_test;
	int          total_checks;
	int          total_errors;
	int          start_checks;
	int          start_errors;
	integer      seed;

	mem_stage dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.read_addr    (read_addr),
		.write_addr   (write_addr),
		.write_data   (write_data),
		.write_enable (write_enable),
		.mode         (mode),
		.read_result  (read_result),
		.invalid      (invalid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ########################################
	// Reference model
	// ########################################

	function automatic logic is_misaligned(input mem_mode_t m, input logic [31:0] addr);
		logic bad;
		case (m)
			mode_w:          bad = (addr[1:0] != 2'b00);
			mode_h, mode_hu: bad = addr[0];
			default:         bad = 1'b0;
		endcase
		return bad;
	endfunction

	// Expected load value built from the byte model; bytes are little endian.
	function automatic logic [31:0] ref_load(input mem_mode_t m, input logic [31:0] addr,
			input logic inv);
		logic [31:0] res;
		logic [15:0] half;
		logic [7:0]  byt;
		half = {shadow[{addr[AW-1:2], addr[1], 1'b1}], shadow[{addr[AW-1:2], addr[1], 1'b0}]};
		byt  = shadow[addr[AW-1:0]];
		case (m)
			mode_w:  res = {shadow[{addr[AW-1:2], 2'b11}], shadow[{addr[AW-1:2], 2'b10}],
				shadow[{addr[AW-1:2], 2'b01}], shadow[{addr[AW-1:2], 2'b00}]};
			mode_h:  res = {{16{half[15]}}, half};
			mode_hu: res = {16'h0000, half};
			mode_b:  res = {{24{byt[7]}}, byt};
			mode_bu: res = {24'h00_0000, byt};
			default: res = 32'h0000_0000;
		endcase
		if (inv) begin
			res = 32'h0000_0000;
		end
		return res;
	endfunction

	task automatic update_shadow(input mem_mode_t m, input logic [31:0] addr,
			input logic [31:0] data);
		if (!is_misaligned(m, addr)) begin
			case (m)
				mode_w: begin
					shadow[{addr[AW-1:2], 2'b00}] = data[7:0];
					shadow[{addr[AW-1:2], 2'b01}] = data[15:8];
					shadow[{addr[AW-1:2], 2'b10}] = data[23:16];
					shadow[{addr[AW-1:2], 2'b11}] = data[31:24];
				end
				mode_h: begin
					shadow[{addr[AW-1:2], addr[1], 1'b0}] = data[7:0];
					shadow[{addr[AW-1:2], addr[1], 1'b1}] = data[15:8];
				end
				mode_b: shadow[addr[AW-1:0]] = data[7:0];
				default: ; // Unsigned modes and idle cycles write nothing.
			endcase
		end
	endtask

	// ########################################
	// Stimulus and checking
	// ########################################

	// One access per cycle; expected values come from the model before the store lands.
	task automatic do_cycle(input logic we, input mem_mode_t m, input logic [31:0] raddr,
			input logic [31:0] waddr, input logic [31:0] wdata);
		logic inv;
		@(posedge clk);
		write_enable <= we;
		mode         <= m;
		read_addr    <= raddr;
		write_addr   <= waddr;
		write_data   <= wdata;
		inv         = is_misaligned(m, we ? waddr : raddr);
		exp_invalid = inv;
		exp_result  = ref_load(m, raddr, inv);
		check_en    = 1'b1;
		if (we) begin
			update_shadow(m, waddr, wdata);
		end
	endtask

	task automatic store_then_check(input mem_mode_t m, input logic [31:0] addr,
			input logic [31:0] data);
		do_cycle(1'b1, m, addr, addr, data);
		do_cycle(1'b0, mode_w, {addr[31:2], 2'b00}, 32'h0, 32'h0); // Word readback.
	endtask

	task automatic start_test(input string name);
		cur_test     = name;
		start_checks = total_checks;
		start_errors = total_errors;
	endtask

	task automatic finish_test();
		@(posedge clk);
		check_en = 1'b0;
		write_enable <= 1'b0;
		mode         <= mode_none;
		$display("%-14s %0d checks, %0d errors", cur_test, total_checks - start_checks,
			total_errors - start_errors);
	endtask

	// Outputs are combinational, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (check_en) begin
			total_checks++;
			if (read_result !== exp_result) begin
				$display("[FAIL] %s read_result expected %h actual %h", cur_test, exp_result,
					read_result);
				total_errors++;
			end
			if (invalid !== exp_invalid) begin
				$display("[FAIL] %s invalid expected %0b actual %0b", cur_test, exp_invalid,
					invalid);
				total_errors++;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns.", TIMEOUT_NS);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int          kind;
		int          m_idx;
		logic [31:0] raddr;
		logic [31:0] waddr;
		logic [31:0] wdata;
		seed         = 32'hb319e9d6;
		rst_n        = 1'b0;
		read_addr    = 32'h0;
		write_addr   = 32'h0;
		write_data   = 32'h0;
		write_enable = 1'b0;
		mode         = mode_none;
		check_en     = 1'b0;
		exp_result   = 32'h0;
		exp_invalid  = 1'b0;
		for (int i = 0; i < (1 << AW); i++) begin
			shadow[i] = 8'h00;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		start_test("reset_zero");
		for (int i = 0; i < 8; i++) begin
			do_cycle(1'b0, mode_w, 32'(i * 132), 32'h0, 32'h0);
		end
		finish_test();

		start_test("word_lanes");
		store_then_check(mode_w, 32'h0000_0020, 32'h8421_f07e);
		store_then_check(mode_w, 32'h0000_0024, 32'h7f80_01ff);
		for (int a = 32'h20; a < 32'h28; a++) begin
			for (int k = 1; k <= 5; k++) begin
				do_cycle(1'b0, mem_mode_t'(k[2:0]), 32'(a), 32'h0, 32'h0);
			end
		end
		finish_test();

		start_test("partial_store");
		store_then_check(mode_w, 32'h0000_0040, 32'h1122_3344);
		store_then_check(mode_h, 32'h0000_0042, 32'h0000_beef);
		store_then_check(mode_b, 32'h0000_0041, 32'hffff_ffa5);
		store_then_check(mode_b, 32'h0000_0043, 32'h0000_0077);
		store_then_check(mode_h, 32'h0000_0040, 32'h1234_9abc);
		finish_test();

		start_test("misaligned");
		store_then_check(mode_w, 32'h0000_0060, 32'hdead_beef);
		store_then_check(mode_w, 32'h0000_0061, 32'h1111_1111);
		store_then_check(mode_w, 32'h0000_0062, 32'h2222_2222);
		store_then_check(mode_h, 32'h0000_0063, 32'h3333_3333);
		store_then_check(mode_h, 32'h0000_0061, 32'h4444_4444);
		do_cycle(1'b0, mode_w, 32'h0000_0062, 32'h0, 32'h0);
		do_cycle(1'b0, mode_h, 32'h0000_0061, 32'h0, 32'h0);
		do_cycle(1'b0, mode_hu, 32'h0000_0063, 32'h0, 32'h0);
		do_cycle(1'b0, mode_w, 32'h0000_0063, 32'h0, 32'h0);
		finish_test();

		start_test("idle_modes");
		do_cycle(1'b0, mode_none, 32'h0000_0060, 32'h0, 32'h0);
		do_cycle(1'b0, mode_none, 32'h0000_0041, 32'h0, 32'h0);
		do_cycle(1'b0, mode_w, 32'h0000_0040, 32'h0000_0080, 32'hffff_ffff); // Enable low.
		do_cycle(1'b0, mode_w, 32'h0000_0080, 32'h0, 32'h0);
		store_then_check(mode_hu, 32'h0000_0084, 32'hffff_ffff);
		store_then_check(mode_bu, 32'h0000_0084, 32'hffff_ffff);
		store_then_check(mode_none, 32'h0000_0084, 32'hffff_ffff);
		finish_test();

		// ########################################
		// Random mix
		// ########################################

		start_test("random_mix");
		for (int i = 0; i < RANDOM_OPS; i++) begin
			kind  = {$random(seed)} % 3;
			m_idx = {$random(seed)} % 6;
			raddr = $random(seed);
			waddr = $random(seed);
			wdata = $random(seed);
			raddr[AW-1:6] = '0; // A small window makes loads hit earlier stores.
			waddr[AW-1:6] = '0;
			case (kind)
				0:       do_cycle(1'b0, mem_mode_t'(m_idx[2:0]), raddr, waddr, wdata);
				1:       do_cycle(1'b1, mem_mode_t'(m_idx[2:0]), waddr, waddr, wdata);
				default: do_cycle(1'b1, mem_mode_t'(m_idx[2:0]), raddr, waddr, wdata);
			endcase
		end
		finish_test();

		$display("Total: %0d checks, %0d errors", total_checks, total_errors);
		if ((total_errors == 0) && (total_checks > 0)) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+source
source/mem_pkg.sv
source/mem_access_check.sv
source/data_ram.sv
source/load_align.sv
source/mem_stage.sv
verification/mem_stage_tb.sv

/* Makefile */
# Verilator flow for the data-memory stage.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= mem_stage_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only when the pass message shows up in the output.
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
